// ==== project.f ====
+incdir+include
rtl/row_driver_pkg.sv
rtl/input_buffer.sv
rtl/wordline_decoder.sv
rtl/bitline_phase_decoder.sv
rtl/eflash_row_driver.sv
verification/tb_eflash_row_driver.sv

// ==== Makefile ====
TOP := tb_eflash_row_driver
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	verilator --lint-only -Wall +incdir+include \
		rtl/row_driver_pkg.sv rtl/input_buffer.sv rtl/wordline_decoder.sv \
		rtl/bitline_phase_decoder.sv rtl/eflash_row_driver.sv \
		--top-module eflash_row_driver

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_eflash_row_driver.sv ====
// eflash row driver testbench: table-driven decoder checks and input buffer readback
`include "row_driver_cfg.svh"

module tb_eflash_row_driver;

    localparam int op_era = int'(`OP_ERASE);
    localparam int op_prg = int'(`OP_PROGRAM);
    localparam int op_par = int'(`OP_PARALLEL);
    localparam int op_rbr = int'(`OP_RBR);
    localparam int hv_er  = int'(`HV_ERASE);
    localparam int hv_pg  = int'(`HV_PROGRAM);
    localparam int hv_rd  = int'(`HV_READ);

    // sel kind: 0 none, 1 addressed row, 2 same row in every block, 3 all rows
    // flags: {rsel[1:0], adc_en1, adc_en2, qdac, buf_wr_en1, buf_wr_en2}
    typedef struct packed {
        logic                       en;
        logic [2:0]                 mode;
        logic [`PHASE_W-1:0]        phase;
        logic [`ROW_ADDR_W-1:0]     row;
        logic [1:0]                 col;
        logic [1:0]                 hv;
        logic [1:0]                 wl_kind;
        logic [1:0]                 vp_kind;
        logic [`BLOCK_COUNT-1:0]    duml;
        logic [`BLOCK_COUNT-1:0]    csl;
        logic [`BSEL_W-1:0]         bsel;
        logic [`BLOCK_COUNT-1:0]    csel;
        logic [6:0]                 flags;
    } vec_t;

    logic                               clk;
    logic                               rst_n;
    logic                               pim_en;
    logic [2:0]                         pim_mode;
    logic [`PHASE_W-1:0]                exec_cnt;
    logic [`ROW_ADDR_W-1:0]             row_addr;
    logic [8:0]                         col_addr;
    logic [`DATA_W-1:0]                 data;
    logic [`WORD_IDX_W-1:0]             word_idx;
    logic                               buf_write;
    logic                               buf_read;
    logic [`BUF_CELLS*`CELL_BITS-1:0]   buf_cells;
    logic [1:0]                         hv_mode;
    logic [`ROW_COUNT-1:0]              wl_sel;
    logic [`ROW_COUNT-1:0]              vpass_en;
    logic [`BLOCK_COUNT-1:0]            duml;
    logic [`BLOCK_COUNT-1:0]            csl;
    logic [`BSEL_W-1:0]                 bsel;
    logic [`BLOCK_COUNT-1:0]            csel;
    logic                               adc_en1;
    logic                               adc_en2;
    logic                               qdac;
    logic [1:0]                         rsel;
    logic                               buf_wr_en1;
    logic                               buf_wr_en2;

    vec_t                               vec_q[$];
    int                                 err_cnt = 0;
    int                                 chk_cnt = 0;
    integer                             seed = 32'h3b9b_d7fa;
    logic [`BUF_CELLS*`CELL_BITS-1:0]   model_cells;
    logic [`BUF_CELLS*`CELL_BITS-1:0]   exp_cells;

    eflash_row_driver dut0 (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .pim_en_i       (pim_en),
        .pim_mode_i     (pim_mode),
        .exec_cnt_i     (exec_cnt),
        .row_addr_i     (row_addr),
        .col_addr_i     (col_addr),
        .data_i         (data),
        .word_idx_i     (word_idx),
        .in_buf_write_i (buf_write),
        .in_buf_read_i  (buf_read),
        .buf_cells_o    (buf_cells),
        .hv_mode_o      (hv_mode),
        .wl_sel_o       (wl_sel),
        .vpass_en_o     (vpass_en),
        .duml_o         (duml),
        .csl_o          (csl),
        .bsel_o         (bsel),
        .csel_o         (csel),
        .adc_en1_o      (adc_en1),
        .adc_en2_o      (adc_en2),
        .qdac_o         (qdac),
        .rsel_o         (rsel),
        .buf_wr_en1_o   (buf_wr_en1),
        .buf_wr_en2_o   (buf_wr_en2)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_vec(input int en, input int mode, input int phase, input int row,
                           input int col, input int hv, input int wl_kind, input int vp_kind,
                           input int duml_e, input int csl_e, input int bsel_e,
                           input int csel_e, input int flags);
        vec_t v;
        v.en      = 1'(en);
        v.mode    = 3'(mode);
        v.phase   = 4'(phase);
        v.row     = 7'(row);
        v.col     = 2'(col);
        v.hv      = 2'(hv);
        v.wl_kind = 2'(wl_kind);
        v.vp_kind = 2'(vp_kind);
        v.duml    = 8'(duml_e);
        v.csl     = 8'(csl_e);
        v.bsel    = bsel_e;
        v.csel    = 8'(csel_e);
        v.flags   = 7'(flags);
        vec_q.push_back(v);
    endtask

    task automatic build_table();
        // erase and program over rows 19, 126, 37 and 64 in blocks 1, 7, 2 and 4
        add_vec(1, op_era, 0, 19, 1, hv_er, 1, 3, 0, 0, 'hffffffff, 'h02, 'b0000100);
        add_vec(1, op_era, 5, 126, 3, hv_er, 1, 3, 0, 0, 'hffffffff, 'h80, 'b0000100);
        add_vec(1, op_prg, 0, 37, 1, hv_pg, 1, 1, 0, 'hff, 'h02020202, 'h04, 'b0000100);
        add_vec(1, op_prg, 9, 64, 3, hv_pg, 1, 1, 0, 'hff, 'h08080808, 'h10, 'b0000100);
        // row-by-row at row 53, block 3, column group 2
        add_vec(1, op_rbr, 8, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 7, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 6, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 5, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 4, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 3, 53, 2, hv_rd, 1, 1, 'h08, 0, 'h04040404, 0, 'b0100100);
        add_vec(1, op_rbr, 2, 53, 2, hv_rd, 1, 1, 0, 0, 0, 'h08, 'b0100100);
        add_vec(1, op_rbr, 1, 53, 2, hv_rd, 1, 1, 0, 0, 0, 'h08, 'b0110100);
        add_vec(1, op_rbr, 0, 53, 2, hv_rd, 1, 1, 0, 0, 0, 'h08, 'b0110110);
        add_vec(1, op_rbr, 12, 53, 2, hv_rd, 1, 1, 0, 0, 0, 0, 'b0100100);
        // parallel at row-in-block 10, column group 0
        add_vec(1, op_par, 11, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 10, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 9, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 8, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 7, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 6, 42, 0, hv_rd, 2, 2, 'hff, 0, 'h01010101, 0, 'b1000100);
        add_vec(1, op_par, 5, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1000100);
        add_vec(1, op_par, 4, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1010100);
        add_vec(1, op_par, 3, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1010010);
        add_vec(1, op_par, 2, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1000000);
        add_vec(1, op_par, 1, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1001000);
        add_vec(1, op_par, 0, 42, 0, hv_rd, 2, 2, 0, 0, 0, 'hff, 'b1001001);
        add_vec(1, op_par, 13, 42, 0, hv_rd, 2, 2, 0, 0, 0, 0, 'b1000100);
        // unused codes and enable low
        add_vec(1, 'b011, 4, 53, 2, 0, 0, 3, 0, 0, 0, 0, 'b0000100);
        add_vec(1, 'b111, 0, 53, 2, 0, 0, 3, 0, 0, 0, 0, 'b0000100);
        add_vec(1, 'b000, 1, 53, 2, 0, 0, 3, 0, 0, 0, 0, 'b0000100);
        add_vec(0, op_prg, 0, 37, 1, 0, 0, 3, 0, 0, 0, 0, 'b0000100);
        add_vec(0, op_par, 3, 42, 0, 0, 0, 3, 0, 0, 0, 0, 'b0000100);
    endtask

    // row r is selected when it matches the rule of the given kind
    function automatic logic [`ROW_COUNT-1:0] sel_pattern(input logic [1:0] kind,
                                                          input logic [`ROW_ADDR_W-1:0] row);
        logic [`ROW_COUNT-1:0] p;
        p = '0;
        for (int r = 0; r < `ROW_COUNT; r++) begin
            case (kind)
                2'd1: p[r] = (r == int'(row));
                2'd2: p[r] = (r % `ROWS_PER_BLOCK == int'(row) % `ROWS_PER_BLOCK);
                2'd3: p[r] = 1'b1;
                default: ;
            endcase
        end
        return p;
    endfunction

    task automatic check(input string name, input logic [511:0] act, input logic [511:0] exp);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s at %0t: got 'h%0h, expected 'h%0h", name, $time, act, exp);
        end
    endtask

    task automatic drive_vec(input vec_t v);
        pim_en   = v.en;
        pim_mode = v.mode;
        exec_cnt = v.phase;
        row_addr = v.row;
        // only the low two column bits pick the group
        col_addr = {7'($random(seed)), v.col};
    endtask

    task automatic check_outputs(input vec_t v);
        check("hv_mode_o", hv_mode, v.hv);
        check("wl_sel_o", wl_sel, sel_pattern(v.wl_kind, v.row));
        check("vpass_en_o", vpass_en, sel_pattern(v.vp_kind, v.row));
        check("duml_o", duml, v.duml);
        check("csl_o", csl, v.csl);
        check("bsel_o", bsel, v.bsel);
        check("csel_o", csel, v.csel);
        check("rsel_o", rsel, v.flags[6:5]);
        check("adc_en1_o", adc_en1, v.flags[4]);
        check("adc_en2_o", adc_en2, v.flags[3]);
        check("qdac_o", qdac, v.flags[2]);
        check("buf_wr_en1_o", buf_wr_en1, v.flags[1]);
        check("buf_wr_en2_o", buf_wr_en2, v.flags[0]);
        check("buf_cells_o", buf_cells, '0);
    endtask

    initial begin
        vec_t rst_vec;
        rst_n       = 1'b0;
        pim_en      = 1'b0;
        pim_mode    = 3'b000;
        exec_cnt    = '0;
        row_addr    = '0;
        col_addr    = '0;
        data        = '0;
        word_idx    = '0;
        buf_write   = 1'b0;
        buf_read    = 1'b0;
        model_cells = '0;
        rst_vec         = '0;
        rst_vec.vp_kind = 2'd3;
        rst_vec.flags   = 7'b0000100;
        build_table();

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_outputs(rst_vec);

        foreach (vec_q[i]) begin
            drive_vec(vec_q[i]);
            @(posedge clk);
            #2;
            check_outputs(vec_q[i]);
        end

        // cell 16w+c takes field c of word w
        pim_en   = 1'b0;
        pim_mode = 3'b000;
        for (int w = 0; w < 16; w++) begin
            data      = $random(seed);
            word_idx  = 4'(w);
            buf_write = 1'b1;
            for (int c = 0; c < 16; c++) begin
                model_cells[(16 * w + c) * 2 +: 2] = data[2 * c +: 2];
            end
            @(posedge clk);
            #2;
        end
        buf_write = 1'b0;
        buf_read  = 1'b1;
        pim_mode  = 3'(op_par);
        @(posedge clk);
        #2;
        check("buf_cells_o", buf_cells, model_cells);

        exp_cells = '0;
        for (int c = 0; c < `RBR_CELLS; c++) begin
            exp_cells[2 * c +: 2] = model_cells[2 * c +: 2];
        end
        pim_mode = 3'(op_rbr);
        @(posedge clk);
        #2;
        check("buf_cells_o", buf_cells, exp_cells);

        buf_read = 1'b0;
        @(posedge clk);
        #2;
        check("buf_cells_o", buf_cells, '0);

        $display("errors: %0d of %0d checks", err_cnt, chk_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #1;
        #((vec_q.size() + 64 + 8) * 20 * 2);
        $display("timeout: the tests did not reach their end in time");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== rtl/eflash_row_driver.sv ====
// eflash row driver top: input buffer, word-line decoder and bit-line phase decoder on shared controls
`include "row_driver_cfg.svh"

module eflash_row_driver (
    input  logic                               clk_i,
    input  logic                               rst_ni,

    input  logic                               pim_en_i,
    input  logic [2:0]                         pim_mode_i,
    input  logic [`PHASE_W-1:0]                exec_cnt_i,
    input  logic [`ROW_ADDR_W-1:0]             row_addr_i,
    input  logic [8:0]                         col_addr_i,

    input  logic [`DATA_W-1:0]                 data_i,
    input  logic [`WORD_IDX_W-1:0]             word_idx_i,
    input  logic                               in_buf_write_i,
    input  logic                               in_buf_read_i,
    output logic [`BUF_CELLS*`CELL_BITS-1:0]   buf_cells_o,

    // high-voltage switch
    output logic [1:0]                         hv_mode_o,
    output logic [`ROW_COUNT-1:0]              wl_sel_o,
    output logic [`ROW_COUNT-1:0]              vpass_en_o,

    // array and sense controls
    output logic [`BLOCK_COUNT-1:0]            duml_o,
    output logic [`BLOCK_COUNT-1:0]            csl_o,
    output logic [`BSEL_W-1:0]                 bsel_o,
    output logic [`BLOCK_COUNT-1:0]            csel_o,
    output logic                               adc_en1_o,
    output logic                               adc_en2_o,
    output logic                               qdac_o,
    output logic [1:0]                         rsel_o,
    output logic                               buf_wr_en1_o,
    output logic                               buf_wr_en2_o
);

    row_driver_pkg::row_addr_u row_addr;

    assign row_addr = row_addr_i;

    input_buffer u_input_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .pim_mode_i  (pim_mode_i),
        .data_i      (data_i),
        .word_idx_i  (word_idx_i),
        .write_i     (in_buf_write_i),
        .read_i      (in_buf_read_i),
        .buf_cells_o (buf_cells_o)
    );

    wordline_decoder u_wordline_decoder (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pim_en_i   (pim_en_i),
        .pim_mode_i (pim_mode_i),
        .row_addr_i (row_addr),
        .hv_mode_o  (hv_mode_o),
        .wl_sel_o   (wl_sel_o),
        .vpass_en_o (vpass_en_o)
    );

    // column group is the interleave position inside each bit-line byte
    bitline_phase_decoder u_bitline_phase_decoder (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pim_en_i     (pim_en_i),
        .pim_mode_i   (pim_mode_i),
        .exec_cnt_i   (exec_cnt_i),
        .row_addr_i   (row_addr),
        .col_group_i  (col_addr_i[1:0]),
        .duml_o       (duml_o),
        .csl_o        (csl_o),
        .bsel_o       (bsel_o),
        .csel_o       (csel_o),
        .adc_en1_o    (adc_en1_o),
        .adc_en2_o    (adc_en2_o),
        .qdac_o       (qdac_o),
        .rsel_o       (rsel_o),
        .buf_wr_en1_o (buf_wr_en1_o),
        .buf_wr_en2_o (buf_wr_en2_o)
    );

endmodule

// ==== rtl/bitline_phase_decoder.sv ====
// bit-line phase decoder: registered bit-line, block, ADC, DAC and output-buffer strobes per phase
`include "row_driver_cfg.svh"

module bitline_phase_decoder (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic                            pim_en_i,
    input  logic [2:0]                      pim_mode_i,
    input  logic [`PHASE_W-1:0]             exec_cnt_i,
    input  row_driver_pkg::row_addr_u       row_addr_i,
    input  logic [1:0]                      col_group_i,

    output logic [`BLOCK_COUNT-1:0]         duml_o,
    output logic [`BLOCK_COUNT-1:0]         csl_o,
    output logic [`BSEL_W-1:0]              bsel_o,
    output logic [`BLOCK_COUNT-1:0]         csel_o,
    output logic                            adc_en1_o,
    output logic                            adc_en2_o,
    output logic                            qdac_o,
    output logic [1:0]                      rsel_o,
    output logic                            buf_wr_en1_o,
    output logic                            buf_wr_en2_o
);

    localparam int bsel_stride = `BSEL_W / `COL_GROUPS;

    logic [`BSEL_W-1:0]         col_pattern;
    logic [`BLOCK_COUNT-1:0]    blk_onehot;
    logic [`BLOCK_COUNT-1:0]    duml_d, csl_d, csel_d;
    logic [`BSEL_W-1:0]         bsel_d;
    logic                       adc_en1_d, adc_en2_d, qdac_d;
    logic [1:0]                 rsel_d;
    logic                       buf_wr_en1_d, buf_wr_en2_d;

    always_comb begin
        col_pattern = '0;
        for (int k = 0; k < `COL_GROUPS; k++) begin
            col_pattern[k * bsel_stride + col_group_i] = 1'b1;
        end
        blk_onehot = '0;
        blk_onehot[row_addr_i.part.block_idx] = 1'b1;
    end

    always_comb begin
        duml_d       = '0;
        csl_d        = '0;
        bsel_d       = '0;
        csel_d       = '0;
        adc_en1_d    = 1'b0;
        adc_en2_d    = 1'b0;
        qdac_d       = 1'b1;
        rsel_d       = '0;
        buf_wr_en1_d = 1'b0;
        buf_wr_en2_d = 1'b0;
        if (pim_en_i) begin
            case (pim_mode_i)
                `OP_ERASE: begin
                    bsel_d = '1;
                    csel_d = blk_onehot;
                end
                `OP_PROGRAM: begin
                    csl_d  = '1;
                    bsel_d = col_pattern;
                    csel_d = blk_onehot;
                end
                `OP_RBR: begin
                    rsel_d = `RSEL_RBR;
                    // precharge through the block dummy line, then sense on adc 1
                    if (exec_cnt_i inside {[4'd3:4'd8]}) begin
                        duml_d = blk_onehot;
                        bsel_d = col_pattern;
                    end else if (exec_cnt_i <= 4'd2) begin
                        csel_d       = blk_onehot;
                        adc_en1_d    = (exec_cnt_i <= 4'd1);
                        buf_wr_en1_d = (exec_cnt_i == 4'd0);
                    end
                end
                `OP_PARALLEL: begin
                    rsel_d = `RSEL_PARALLEL;
                    if (exec_cnt_i inside {[4'd6:4'd11]}) begin
                        duml_d = '1;
                        bsel_d = col_pattern;
                    end else if (exec_cnt_i <= 4'd5) begin
                        csel_d       = '1;
                        adc_en1_d    = (exec_cnt_i inside {4'd3, 4'd4});
                        adc_en2_d    = (exec_cnt_i <= 4'd1);
                        // charge DAC active from phase 3 on, low means on
                        qdac_d       = (exec_cnt_i > 4'd3);
                        buf_wr_en1_d = (exec_cnt_i == 4'd3);
                        buf_wr_en2_d = (exec_cnt_i == 4'd0);
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            duml_o       <= '0;
            csl_o        <= '0;
            bsel_o       <= '0;
            csel_o       <= '0;
            adc_en1_o    <= 1'b0;
            adc_en2_o    <= 1'b0;
            qdac_o       <= 1'b1;
            rsel_o       <= '0;
            buf_wr_en1_o <= 1'b0;
            buf_wr_en2_o <= 1'b0;
        end else begin
            duml_o       <= duml_d;
            csl_o        <= csl_d;
            bsel_o       <= bsel_d;
            csel_o       <= csel_d;
            adc_en1_o    <= adc_en1_d;
            adc_en2_o    <= adc_en2_d;
            qdac_o       <= qdac_d;
            rsel_o       <= rsel_d;
            buf_wr_en1_o <= buf_wr_en1_d;
            buf_wr_en2_o <= buf_wr_en2_d;
        end
    end

    // the two ADCs share the sense path
    a_adc_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(adc_en1_o && adc_en2_o)
    ) else $error("both ADC enables high in the same cycle");

endmodule

// ==== rtl/wordline_decoder.sv ====
// word-line decoder: registered high-voltage mode, word-line select and pass-enable per operation
`include "row_driver_cfg.svh"

module wordline_decoder (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic                            pim_en_i,
    input  logic [2:0]                      pim_mode_i,
    input  row_driver_pkg::row_addr_u       row_addr_i,

    output logic [1:0]                      hv_mode_o,
    output logic [`ROW_COUNT-1:0]           wl_sel_o,
    output logic [`ROW_COUNT-1:0]           vpass_en_o
);

    logic                   single_row;
    logic [`ROW_COUNT-1:0]  row_onehot;
    logic [`ROW_COUNT-1:0]  row_stride;
    logic [1:0]             hv_mode_d;
    logic [`ROW_COUNT-1:0]  wl_sel_d;
    logic [`ROW_COUNT-1:0]  vpass_en_d;

    assign single_row = pim_en_i && (pim_mode_i == `OP_ERASE || pim_mode_i == `OP_PROGRAM
                                     || pim_mode_i == `OP_RBR);

    // addressed row, and the same row in every block for parallel read
    always_comb begin
        row_onehot = '0;
        row_onehot[row_addr_i.row_num] = 1'b1;
        row_stride = '0;
        for (int b = 0; b < `BLOCK_COUNT; b++) begin
            row_stride[b * `ROWS_PER_BLOCK + row_addr_i.part.row_in_blk] = 1'b1;
        end
    end

    always_comb begin
        hv_mode_d  = '0;
        wl_sel_d   = '0;
        vpass_en_d = '1;
        if (pim_en_i) begin
            case (pim_mode_i)
                `OP_ERASE: begin
                    hv_mode_d = `HV_ERASE;
                    wl_sel_d  = row_onehot;
                end
                `OP_PROGRAM: begin
                    hv_mode_d  = `HV_PROGRAM;
                    wl_sel_d   = row_onehot;
                    vpass_en_d = row_onehot;
                end
                `OP_RBR: begin
                    hv_mode_d  = `HV_READ;
                    wl_sel_d   = row_onehot;
                    vpass_en_d = row_onehot;
                end
                `OP_PARALLEL: begin
                    hv_mode_d  = `HV_READ;
                    wl_sel_d   = row_stride;
                    vpass_en_d = row_stride;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hv_mode_o  <= '0;
            wl_sel_o   <= '0;
            vpass_en_o <= '1;
        end else begin
            hv_mode_o  <= hv_mode_d;
            wl_sel_o   <= wl_sel_d;
            vpass_en_o <= vpass_en_d;
        end
    end

    // single-row operations must reach the array as exactly one word line
    a_wl_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        single_row |=> $onehot(wl_sel_o)
    ) else $error("word-line select not one-hot for a single-row operation");

endmodule

// ==== rtl/input_buffer.sv ====
// input buffer: 256 two-bit input cells, word-indexed writes, mode-dependent registered readout
`include "row_driver_cfg.svh"

module input_buffer (
    input  logic                               clk_i,
    input  logic                               rst_ni,

    input  logic [2:0]                         pim_mode_i,

    input  logic [`DATA_W-1:0]                 data_i,
    input  logic [`WORD_IDX_W-1:0]             word_idx_i,
    input  logic                               write_i,
    input  logic                               read_i,

    output logic [`BUF_CELLS*`CELL_BITS-1:0]   buf_cells_o
);

    localparam int buf_w = `BUF_CELLS * `CELL_BITS;
    localparam int rbr_w = `RBR_CELLS * `CELL_BITS;

    // cell i sits at bits [2i +: 2]
    logic [buf_w-1:0] cells_q;

    // one word fills sixteen consecutive cells, low field first
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cells_q <= '0;
        end else if (write_i) begin
            cells_q[word_idx_i * `DATA_W +: `DATA_W] <= data_i;
        end
    end

    // readout sees the contents from before a write in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            buf_cells_o <= '0;
        end else if (read_i && pim_mode_i == `OP_PARALLEL) begin
            buf_cells_o <= cells_q;
        end else if (read_i && pim_mode_i == `OP_RBR) begin
            // row-by-row only drives the first column block
            buf_cells_o <= buf_w'(cells_q[rbr_w-1:0]);
        end else begin
            buf_cells_o <= '0;
        end
    end

    // a written word lands in the cells read back on later cycles
    a_write_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        write_i |-> !$isunknown({data_i, word_idx_i})
    ) else $error("input buffer written with unknown data or word index");

endmodule

// ==== rtl/row_driver_pkg.sv ====
// row driver package: row address type shared by the word-line and bit-line decoders
`include "row_driver_cfg.svh"

package row_driver_pkg;

    // same 7 bits, seen either as a row number or as block plus row in block
    typedef union packed {
        logic [`ROW_ADDR_W-1:0] row_num;
        struct packed {
            logic [$clog2(`BLOCK_COUNT)-1:0]    block_idx;
            logic [$clog2(`ROWS_PER_BLOCK)-1:0] row_in_blk;
        } part;
    } row_addr_u;

endpackage

// ==== include/row_driver_cfg.svh ====
// row driver configuration: eflash array geometry, operation and analog control codes
`ifndef ROW_DRIVER_CFG_SVH
`define ROW_DRIVER_CFG_SVH

// array geometry
`define ROW_COUNT       128
`define ROW_ADDR_W      7
`define BLOCK_COUNT     8
`define ROWS_PER_BLOCK  16
`define COL_GROUPS      4
`define BSEL_W          32

// input buffer
`define CELL_BITS       2
`define BUF_CELLS       256
`define RBR_CELLS       32
`define DATA_W          32
`define WORD_IDX_W      4

// execution counter counts down to phase 0
`define PHASE_W         4

// pim operation codes
`define OP_ERASE        3'b001
`define OP_PROGRAM      3'b010
`define OP_PARALLEL     3'b101
`define OP_RBR          3'b110

// high-voltage switch modes
`define HV_ERASE        2'b00
`define HV_PROGRAM      2'b01
`define HV_READ         2'b10

// sense reference select
`define RSEL_RBR        2'b01
`define RSEL_PARALLEL   2'b10

`endif
